// File: common/ql_pkg.sv
package ql_pkg;

  // ==================================================
  // Bus and data widths
  // ==================================================
  typedef logic [8:0]  io_addr_t;     // CPU word address, bits 9:1
  typedef logic [15:0] word_t;        // CPU data bus
  typedef logic [7:0]  byte_t;
  typedef logic [31:0] seconds_t;     // Real-time counter
  typedef logic [63:0] key_matrix_t;  // Row r in bits 8r+7:8r
  typedef logic [2:0]  key_pos_t;     // Row or column index

  // ==================================================
  // Port offsets on address bits 6:1
  // ==================================================
  localparam logic [5:0] PORT_TIMER   = 6'd0;   // Two words, bit 1 ignored
  localparam logic [5:0] PORT_IPCWR   = 6'd1;   // $18003
  localparam logic [5:0] PORT_KEYBD   = 6'd5;   // Row select on bits 9:7
  localparam logic [5:0] PORT_IPCIRQ  = 6'd16;  // $18020/21
  localparam logic [5:0] PORT_DISPLAY = 6'd49;  // $18063

  // IPC commands handled here, the rest are ignored
  localparam logic [3:0] IPC_CMD_STATUS   = 4'd1;
  localparam logic [3:0] IPC_CMD_READ_KEY = 4'd8;
  localparam logic [3:0] IPC_CMD_KEYROW   = 4'd9;

  typedef enum logic [1:0] {
    IPC_IDLE,     // Collecting command nibbles
    IPC_SEND,     // Shifting reply out
    IPC_RECEIVE   // Collecting parameter nibble
  } ipc_state_e;

  // Bit positions in the pending byte
  localparam int IRQ_IPC_BIT   = 1;
  localparam int IRQ_VSYNC_BIT = 3;
  localparam int IRQ_TIMER_BIT = 5;

  // Modifier keys in the matrix
  localparam int KEY_SHIFT_BIT = 56;
  localparam int KEY_CTRL_BIT  = 57;
  localparam int KEY_ALT_BIT   = 58;

  localparam int DISPLAY_MODE_BIT = 3;  // 0 = 512x256, 1 = 256x256

endpackage

// File: ipc/ql_key_encoder.sv
`timescale 1ns/100ps

module ql_key_encoder (
  input  ql_pkg::key_matrix_t i_kbd_matrix,
  output ql_pkg::key_pos_t    o_row,
  output ql_pkg::key_pos_t    o_col,
  output logic                o_shift,
  output logic                o_ctrl,
  output logic                o_alt
);

  ql_pkg::byte_t row_bits;  // Row picked by the row encoder

  always_comb begin
    o_row = 3'd7;  // Also when nothing is pressed
    for (int r = 6; r >= 0; r--)  // Lowest row wins
      if (i_kbd_matrix[8*r +: 8] != 8'h00)
        o_row = ql_pkg::key_pos_t'(r);
  end

  assign row_bits = i_kbd_matrix[{o_row, 3'b000} +: 8];

  always_comb begin
    o_col = 3'd7;
    for (int c = 6; c >= 0; c--)  // Lowest column wins
      if (row_bits[c])
        o_col = ql_pkg::key_pos_t'(c);
  end

  assign o_shift = i_kbd_matrix[ql_pkg::KEY_SHIFT_BIT];
  assign o_ctrl  = i_kbd_matrix[ql_pkg::KEY_CTRL_BIT];
  assign o_alt   = i_kbd_matrix[ql_pkg::KEY_ALT_BIT];

endmodule

// File: ipc/ql_ipc.sv
`timescale 1ns/100ps

module ql_ipc (
  input  logic                clk_cpu,
  input  logic                reset,
  input  logic                i_bit_wr,     // One pulse per IPC write
  input  logic                i_bit,
  input  logic                i_key_event,
  input  ql_pkg::key_pos_t    i_key_row,
  input  ql_pkg::key_pos_t    i_key_col,
  input  logic                i_shift,
  input  logic                i_ctrl,
  input  logic                i_alt,
  input  ql_pkg::key_matrix_t i_kbd_matrix,
  output logic                o_reply_bit
);

  ql_pkg::ipc_state_e state;
  logic [3:0]    bit_cnt;
  logic [3:0]    bit_last;    // Bits in this phase, minus one
  logic [3:0]    nibble;
  logic [3:0]    nibble_next;
  logic [3:0]    cmd;
  ql_pkg::word_t reply;       // MSB goes out first
  logic          key_pressed;

  assign nibble_next = {nibble[2:0], i_bit};  // MSB first
  assign o_reply_bit = reply[15];

  // ==================================================
  // Command FSM
  // ==================================================
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      state       <= ql_pkg::IPC_IDLE;
      bit_cnt     <= 4'd0;
      reply       <= '0;
      key_pressed <= 1'b0;
    end else begin
      if (i_bit_wr) begin
        case (state)
          ql_pkg::IPC_IDLE: begin
            nibble  <= nibble_next;
            bit_cnt <= bit_cnt + 4'd1;
            if (bit_cnt[1:0] == 2'd3) begin  // Fourth bit, command complete
              cmd     <= nibble_next;
              bit_cnt <= 4'd0;
              case (nibble_next)
                ql_pkg::IPC_CMD_STATUS: begin
                  state       <= ql_pkg::IPC_SEND;
                  bit_last    <= 4'd7;
                  reply       <= {7'b0, key_pressed, 8'h00};
                  key_pressed <= 1'b0;
                end
                ql_pkg::IPC_CMD_READ_KEY: begin
                  state    <= ql_pkg::IPC_SEND;
                  bit_last <= 4'd15;
                  reply    <= {4'b0001, 1'b0, i_shift, i_ctrl, i_alt, 2'b00,
                               i_key_row, i_key_col};
                end
                ql_pkg::IPC_CMD_KEYROW: begin
                  state    <= ql_pkg::IPC_RECEIVE;  // Row number follows
                  bit_last <= 4'd3;
                end
                default: ;  // Sound, serial etc not supported
              endcase
            end
          end
          ql_pkg::IPC_SEND: begin
            reply <= {reply[14:0], 1'b0};
            if (bit_cnt == bit_last) begin
              state   <= ql_pkg::IPC_IDLE;
              bit_cnt <= 4'd0;
            end else begin
              bit_cnt <= bit_cnt + 4'd1;
            end
          end
          ql_pkg::IPC_RECEIVE: begin
            nibble <= nibble_next;
            if (bit_cnt == bit_last) begin
              bit_cnt <= 4'd0;
              if (cmd == ql_pkg::IPC_CMD_KEYROW) begin
                state    <= ql_pkg::IPC_SEND;
                bit_last <= 4'd7;
                reply    <= {i_kbd_matrix[{nibble_next[2:0], 3'b000} +: 8], 8'h00};
              end else begin
                state <= ql_pkg::IPC_IDLE;
              end
            end else begin
              bit_cnt <= bit_cnt + 4'd1;
            end
          end
          default: begin
            state   <= ql_pkg::IPC_IDLE;
            bit_cnt <= 4'd0;
          end
        endcase
      end
      // New key wins over the status clear
      if (i_key_event)
        key_pressed <= 1'b1;
    end
  end

endmodule

// File: hw/ql_rtc.sv
`timescale 1ns/100ps

module ql_rtc #(
  parameter int p_ticks_per_second = 27000000
) (
  input  logic             clk_cpu,
  input  logic             reset,
  input  logic             i_clear,        // Timer reset write
  input  logic             i_adjust,       // Timer adjust write
  input  ql_pkg::byte_t    i_adjust_byte,
  output ql_pkg::seconds_t o_seconds
);

  logic [$clog2(p_ticks_per_second)-1:0] prescaler;
  logic       tick;        // One cycle after prescaler wrap
  logic [1:0] adj_index;   // Next byte to load, 0 is LSB

  // ==================================================
  // Prescaler, free running
  // ==================================================
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      prescaler <= '0;
      tick      <= 1'b0;
    end else begin
      tick <= 1'b0;
      if (prescaler == p_ticks_per_second - 1) begin
        prescaler <= '0;
        tick      <= 1'b1;
      end else begin
        prescaler <= prescaler + 1'b1;
      end
    end
  end

  // ==================================================
  // Seconds counter
  // ==================================================
  always_ff @(posedge clk_cpu) begin
    if (reset || i_clear) begin
      o_seconds <= '0;
      adj_index <= 2'd0;
    end else if (i_adjust) begin
      // Software loads the count byte by byte, tick lost here
      o_seconds[{adj_index, 3'b000} +: 8] <= i_adjust_byte;
      adj_index <= adj_index + 2'd1;
    end else if (tick) begin
      o_seconds <= o_seconds + 1'b1;
    end
  end

endmodule

// File: hw/ql_irq.sv
`timescale 1ns/100ps

module ql_irq (
  input  logic          clk_cpu,
  input  logic          reset,
  input  logic          i_vsync,
  input  logic          i_key_event,
  input  logic          i_seconds_lsb,
  input  logic          i_ack_wr,      // Write to $18021
  input  logic [4:0]    i_ack,         // Acknowledge bits, one per source
  output ql_pkg::byte_t o_pending,
  output logic          o_irq
);

  logic r_vsync;     // Input register
  logic r_vsync_d;   // Edge register
  logic vsync_flag;
  logic key_flag;    // Reported as the IPC interrupt

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      r_vsync    <= 1'b0;
      r_vsync_d  <= 1'b0;
      vsync_flag <= 1'b0;
      key_flag   <= 1'b0;
    end else begin
      r_vsync   <= i_vsync;
      r_vsync_d <= r_vsync;
      // Acknowledge beats a new request in the same cycle
      if (i_ack_wr && i_ack[ql_pkg::IRQ_VSYNC_BIT])
        vsync_flag <= 1'b0;
      else if (r_vsync_d && !r_vsync)  // Falling edge
        vsync_flag <= 1'b1;
      if (i_ack_wr && i_ack[ql_pkg::IRQ_IPC_BIT])
        key_flag <= 1'b0;
      else if (i_key_event)
        key_flag <= 1'b1;
    end
  end

  always_comb begin
    o_pending = '0;
    o_pending[ql_pkg::IRQ_IPC_BIT]   = key_flag;
    o_pending[ql_pkg::IRQ_VSYNC_BIT] = vsync_flag;
    o_pending[ql_pkg::IRQ_TIMER_BIT] = i_seconds_lsb;  // Not a request
  end

  assign o_irq = vsync_flag | key_flag;  // Level to IPL

endmodule

// File: hw/ql_bus_regs.sv
`timescale 1ns/100ps

module ql_bus_regs (
  input  logic                clk_cpu,
  input  logic                reset,
  input  logic                i_cs,
  input  logic                i_rw,
  input  logic                i_uds_n,
  input  logic                i_lds_n,
  input  ql_pkg::io_addr_t    i_addr,    // Index 0 is address bit 1
  input  ql_pkg::word_t       i_wdata,
  input  ql_pkg::seconds_t    i_seconds,
  input  ql_pkg::byte_t       i_irq_pending,
  input  logic                i_ipc_reply_bit,
  input  ql_pkg::key_matrix_t i_kbd_matrix,
  output ql_pkg::word_t       o_rdata,
  output logic                o_display_mode,
  output logic                o_rtc_clear,
  output logic                o_rtc_adjust,
  output ql_pkg::byte_t       o_rtc_byte,
  output logic                o_irq_ack_wr,
  output logic [4:0]          o_irq_ack,
  output logic                o_ipc_bit_wr,
  output logic                o_ipc_bit
);

  logic          sel_timer;     // Both timer words
  logic          sel_timer_hi;  // $18000 word only
  logic          sel_keybd;
  logic          sel_ipcirq;
  logic          sel_display;
  logic          cpu_wr;
  logic          ipcwr_strobe;
  logic          r_ipcwr_strobe;  // Previous cycle, for edge detect
  ql_pkg::byte_t kbd_row;

  // ==================================================
  // Address decode
  // ==================================================
  assign sel_timer    = i_cs && i_addr[5:1] == ql_pkg::PORT_TIMER[5:1];
  assign sel_timer_hi = i_cs && i_addr[5:0] == ql_pkg::PORT_TIMER;
  assign sel_keybd    = i_cs && i_addr[5:0] == ql_pkg::PORT_KEYBD;
  assign sel_ipcirq   = i_cs && i_addr[5:0] == ql_pkg::PORT_IPCIRQ;
  assign sel_display  = i_cs && i_addr[5:0] == ql_pkg::PORT_DISPLAY;
  assign cpu_wr       = i_cs && !i_rw;

  // Write strobes, all zero-wait
  assign o_rtc_clear  = cpu_wr && sel_timer_hi && !i_uds_n;
  assign o_rtc_adjust = cpu_wr && sel_timer_hi && !i_lds_n;
  assign o_rtc_byte   = i_wdata[7:0];
  assign o_irq_ack_wr = cpu_wr && sel_ipcirq && !i_lds_n;
  assign o_irq_ack    = i_wdata[4:0];

  // IPC bit goes out on first cycle of the strobe only
  assign ipcwr_strobe = cpu_wr && i_addr[5:0] == ql_pkg::PORT_IPCWR && !i_lds_n;
  assign o_ipc_bit_wr = ipcwr_strobe && !r_ipcwr_strobe;
  assign o_ipc_bit    = i_wdata[1];

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      r_ipcwr_strobe <= 1'b0;
      o_display_mode <= 1'b1;  // 256 mode out of reset
    end else begin
      r_ipcwr_strobe <= ipcwr_strobe;
      if (cpu_wr && sel_display)
        o_display_mode <= i_wdata[ql_pkg::DISPLAY_MODE_BIT];
    end
  end

  // ==================================================
  // Read data
  // ==================================================
  assign kbd_row = i_kbd_matrix[{i_addr[8:6], 3'b000} +: 8];  // Row from A9:A7

  always_comb begin
    if (sel_timer)
      o_rdata = i_addr[0] ? i_seconds[15:0] : i_seconds[31:16];
    else if (sel_keybd)
      o_rdata = {8'h00, kbd_row};
    else if (sel_ipcirq)
      o_rdata = {i_ipc_reply_bit, 7'b0, i_irq_pending};  // IPC never busy
    else
      o_rdata = '0;  // Also when i_cs is low
  end

endmodule

// File: hw/ql_io_top.sv
`timescale 1ns/100ps

module ql_io_top #(
  parameter int p_ticks_per_second = 27000000  // clk_cpu cycles per second
) (
  input  logic                clk_cpu,
  input  logic                reset,
  // CPU side, 68000 style strobes
  input  logic                i_cs,       // VMA inside the I/O window
  input  logic                i_rw,       // 1 = read
  input  logic                i_uds_n,
  input  logic                i_lds_n,
  input  ql_pkg::io_addr_t    i_addr,
  input  ql_pkg::word_t       i_wdata,
  output ql_pkg::word_t       o_rdata,
  // Sources
  input  logic                i_vsync,
  input  logic                i_key_event,  // One pulse per key event
  input  ql_pkg::key_matrix_t i_kbd_matrix,
  output logic                o_irq,
  output logic                o_display_mode
);

  logic               rtc_clear;
  logic               rtc_adjust;
  ql_pkg::byte_t      rtc_byte;
  ql_pkg::seconds_t   seconds;
  logic               irq_ack_wr;
  logic [4:0]         irq_ack;
  ql_pkg::byte_t      irq_pending;
  logic               ipc_bit_wr;
  logic               ipc_bit;
  logic               ipc_reply_bit;
  ql_pkg::key_pos_t   key_row;
  ql_pkg::key_pos_t   key_col;
  logic               key_shift;
  logic               key_ctrl;
  logic               key_alt;

  // ==================================================
  // Decode and register file
  // ==================================================
  ql_bus_regs ql_bus_regs_inst (
    .clk_cpu         (clk_cpu),
    .reset           (reset),
    .i_cs            (i_cs),
    .i_rw            (i_rw),
    .i_uds_n         (i_uds_n),
    .i_lds_n         (i_lds_n),
    .i_addr          (i_addr),
    .i_wdata         (i_wdata),
    .i_seconds       (seconds),
    .i_irq_pending   (irq_pending),
    .i_ipc_reply_bit (ipc_reply_bit),
    .i_kbd_matrix    (i_kbd_matrix),
    .o_rdata         (o_rdata),
    .o_display_mode  (o_display_mode),
    .o_rtc_clear     (rtc_clear),
    .o_rtc_adjust    (rtc_adjust),
    .o_rtc_byte      (rtc_byte),
    .o_irq_ack_wr    (irq_ack_wr),
    .o_irq_ack       (irq_ack),
    .o_ipc_bit_wr    (ipc_bit_wr),
    .o_ipc_bit       (ipc_bit)
  );

  ql_rtc #(
    .p_ticks_per_second (p_ticks_per_second)
  ) ql_rtc_inst (
    .clk_cpu       (clk_cpu),
    .reset         (reset),
    .i_clear       (rtc_clear),
    .i_adjust      (rtc_adjust),
    .i_adjust_byte (rtc_byte),
    .o_seconds     (seconds)
  );

  ql_irq ql_irq_inst (
    .clk_cpu       (clk_cpu),
    .reset         (reset),
    .i_vsync       (i_vsync),
    .i_key_event   (i_key_event),
    .i_seconds_lsb (seconds[0]),  // Shows up as the timer bit
    .i_ack_wr      (irq_ack_wr),
    .i_ack         (irq_ack),
    .o_pending     (irq_pending),
    .o_irq         (o_irq)
  );

  // ==================================================
  // IPC and keyboard
  // ==================================================
  ql_ipc ql_ipc_inst (
    .clk_cpu      (clk_cpu),
    .reset        (reset),
    .i_bit_wr     (ipc_bit_wr),
    .i_bit        (ipc_bit),
    .i_key_event  (i_key_event),
    .i_key_row    (key_row),
    .i_key_col    (key_col),
    .i_shift      (key_shift),
    .i_ctrl       (key_ctrl),
    .i_alt        (key_alt),
    .i_kbd_matrix (i_kbd_matrix),
    .o_reply_bit  (ipc_reply_bit)
  );

  ql_key_encoder ql_key_encoder_inst (
    .i_kbd_matrix (i_kbd_matrix),
    .o_row        (key_row),
    .o_col        (key_col),
    .o_shift      (key_shift),
    .o_ctrl       (key_ctrl),
    .o_alt        (key_alt)
  );

endmodule

// File: testbench/ql_io_checker.sv
`timescale 1ns/100ps

module ql_io_checker (
  input logic          clk_cpu,
  input logic          reset,
  input logic          i_cs,
  input ql_pkg::word_t i_rdata,
  input logic          i_irq,
  input ql_pkg::byte_t i_pending
);

  int fail_count = 0;

  // ==================================================
  // Interrupt level
  // ==================================================
  irq_low_in_reset: assert property (@(posedge clk_cpu) reset |=> !i_irq)
    else begin
      fail_count++;
      $error("o_irq high after a reset cycle");
    end

  irq_low_after_reset: assert property (@(posedge clk_cpu) $fell(reset) |=> !i_irq)
    else begin
      fail_count++;
      $error("o_irq high in the cycle after reset");
    end

  // Level is the OR of the two request flags
  irq_follows_pending: assert property (@(posedge clk_cpu) disable iff (reset)
      i_irq == (i_pending[ql_pkg::IRQ_IPC_BIT] | i_pending[ql_pkg::IRQ_VSYNC_BIT]))
    else begin
      fail_count++;
      $error("o_irq does not match pending bits 1 and 3");
    end

  // ==================================================
  // Read bus
  // ==================================================
  rdata_zero_unselected: assert property (@(posedge clk_cpu) !i_cs |-> i_rdata == '0)
    else begin
      fail_count++;
      $error("o_rdata not zero with i_cs low");
    end

endmodule

bind ql_io_top ql_io_checker ql_io_checker_inst (
  .clk_cpu   (clk_cpu),
  .reset     (reset),
  .i_cs      (i_cs),
  .i_rdata   (o_rdata),
  .i_irq     (o_irq),
  .i_pending (irq_pending)  // Internal wire of the top level
);

// File: testbench/tb_ql_io.sv
`timescale 1ns/100ps

module tb_ql_io;

  logic                clk_cpu;
  logic                reset;
  logic                i_cs;
  logic                i_rw;
  logic                i_uds_n;
  logic                i_lds_n;
  ql_pkg::io_addr_t    i_addr;
  ql_pkg::word_t       i_wdata;
  ql_pkg::word_t       o_rdata;
  logic                i_vsync;
  logic                i_key_event;
  ql_pkg::key_matrix_t i_kbd_matrix;
  logic                o_irq;
  logic                o_display_mode;

  int errors;
  int checks;

  ql_io_top #(
    .p_ticks_per_second (8)  // One second every 8 clocks
  ) ql_io_top_inst (
    .clk_cpu        (clk_cpu),
    .reset          (reset),
    .i_cs           (i_cs),
    .i_rw           (i_rw),
    .i_uds_n        (i_uds_n),
    .i_lds_n        (i_lds_n),
    .i_addr         (i_addr),
    .i_wdata        (i_wdata),
    .o_rdata        (o_rdata),
    .i_vsync        (i_vsync),
    .i_key_event    (i_key_event),
    .i_kbd_matrix   (i_kbd_matrix),
    .o_irq          (o_irq),
    .o_display_mode (o_display_mode)
  );

  initial begin
    clk_cpu = 1'b0;
    forever #20 clk_cpu = ~clk_cpu;  // 40 ns period
  end

  initial begin
    #(2000 * 40);  // 2000 clocks cover the whole test sequence
    $display("Watchdog expired at %0t ns, the tests did not finish", $time);
    $display("SIMULATION FAILED");
    $finish;
  end

  // ==================================================
  // Bus tasks start and end 2 ns after a rising edge
  // ==================================================
  task automatic release_bus();
    i_cs    = 1'b0;
    i_rw    = 1'b1;
    i_uds_n = 1'b1;
    i_lds_n = 1'b1;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_cpu);
    #2;
  endtask

  task automatic write_word(input ql_pkg::io_addr_t addr, input ql_pkg::word_t data,
                            input logic uds_n, input logic lds_n);
    i_cs    = 1'b1;
    i_rw    = 1'b0;
    i_addr  = addr;
    i_wdata = data;
    i_uds_n = uds_n;
    i_lds_n = lds_n;
    wait_cycles(1);  // Takes effect on this edge
    release_bus();
  endtask

  task automatic read_word(input ql_pkg::io_addr_t addr, output ql_pkg::word_t data);
    i_cs    = 1'b1;
    i_rw    = 1'b1;
    i_addr  = addr;
    i_uds_n = 1'b0;
    i_lds_n = 1'b0;
    @(negedge clk_cpu);
    data = o_rdata;  // Settled by mid cycle
    wait_cycles(1);
    release_bus();
  endtask

  task automatic pulse_key_event();
    i_key_event = 1'b1;
    wait_cycles(1);
    i_key_event = 1'b0;
  endtask

  task automatic ipc_send_bit(input logic b);
    write_word({3'b000, ql_pkg::PORT_IPCWR}, {14'h0000, b, 1'b0}, 1'b1, 1'b0);
    wait_cycles(1);  // Strobe low between bits
  endtask

  task automatic ipc_send_nibble(input logic [3:0] n);
    for (int i = 3; i >= 0; i--)
      ipc_send_bit(n[i]);  // MSB first
  endtask

  // Read the reply bit, then clock it on with a dummy write
  task automatic ipc_read_reply(input int nbits, output ql_pkg::word_t value);
    ql_pkg::word_t rd;
    value = '0;
    for (int i = 0; i < nbits; i++) begin
      read_word({3'b000, ql_pkg::PORT_IPCIRQ}, rd);
      value = {value[14:0], rd[15]};
      ipc_send_bit(1'b0);
    end
  endtask

  // ==================================================
  // Reference model and checks
  // ==================================================
  function automatic ql_pkg::byte_t matrix_row(input ql_pkg::key_matrix_t m, input int r);
    return m[8*r +: 8];
  endfunction

  function automatic ql_pkg::word_t read_key_reply(input ql_pkg::key_matrix_t m);
    int row;
    int col;
    row = 7;  // Nothing pressed
    for (int r = 0; r < 8; r++) begin
      if (m[8*r +: 8] != 8'h00) begin
        row = r;
        break;
      end
    end
    col = 7;
    for (int c = 0; c < 8; c++) begin
      if (m[8*row + c]) begin
        col = c;
        break;
      end
    end
    return {4'b0001, 1'b0, m[ql_pkg::KEY_SHIFT_BIT], m[ql_pkg::KEY_CTRL_BIT],
            m[ql_pkg::KEY_ALT_BIT], 2'b00, row[2:0], col[2:0]};
  endfunction

  // Random keys with the lowest rows left empty
  function automatic ql_pkg::key_matrix_t random_matrix(input int empty_rows);
    ql_pkg::key_matrix_t m;
    m = {$urandom, $urandom};
    for (int r = 0; r < empty_rows; r++)
      m[8*r +: 8] = 8'h00;
    return m;
  endfunction

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic expect_within(input string name, input logic [31:0] got,
                               input logic [31:0] lo, input logic [31:0] hi);
    checks++;
    assert (got >= lo && got <= hi) else begin
      errors++;
      $display("Fail at %0t ns: %s expected %h to %h got %h", $time, name, lo, hi, got);
    end
  endtask

  // ==================================================
  // Stimulus
  // ==================================================
  initial begin
    ql_pkg::word_t rd;
    ql_pkg::word_t rd_hi;
    ql_pkg::word_t prev;
    ql_pkg::word_t reply;
    bit            synced;
    void'($urandom(32'h8309));
    errors       = 0;
    checks       = 0;
    reset        = 1'b1;
    i_addr       = '0;
    i_wdata      = '0;
    i_vsync      = 1'b1;
    i_key_event  = 1'b0;
    i_kbd_matrix = '0;
    release_bus();
    repeat (5) @(posedge clk_cpu);
    #2;
    reset = 1'b0;
    wait_cycles(1);
    expect_equal("o_display_mode", o_display_mode, 1'b1);

    // Timer adjust bytes go LSB first
    write_word(9'd0, 16'h0000, 1'b0, 1'b1);
    write_word(9'd0, 16'h0011, 1'b1, 1'b0);
    write_word(9'd0, 16'h0022, 1'b1, 1'b0);
    write_word(9'd0, 16'h0033, 1'b1, 1'b0);
    write_word(9'd0, 16'h0044, 1'b1, 1'b0);
    read_word(9'd0, rd_hi);
    read_word(9'd1, rd);
    expect_within("o_rdata timer count", {rd_hi, rd}, 32'h44332211, 32'h44332212);

    // Timer reset and count lined up just after a tick
    read_word(9'd1, prev);
    synced = 1'b0;
    for (int i = 0; i < 20 && !synced; i++) begin
      read_word(9'd1, rd);
      synced = (rd != prev);
      prev   = rd;
    end
    if (!synced) begin
      errors++;
      $display("Timer counter never advanced within 20 reads");
    end
    write_word(9'd0, 16'h0000, 1'b0, 1'b1);  // Upper strobe clears
    read_word(9'd0, rd_hi);
    expect_equal("o_rdata timer high", rd_hi, 16'h0000);
    read_word(9'd1, rd);
    expect_equal("o_rdata timer low", rd, 16'h0000);
    wait_cycles(24);  // k = 3 seconds
    read_word(9'd1, rd);
    expect_within("o_rdata timer low", rd, 2, 3);

    // Interrupts
    i_vsync = 1'b0;  // Falling edge
    wait_cycles(3);
    read_word({3'b000, ql_pkg::PORT_IPCIRQ}, rd);
    expect_equal("o_rdata[3] vsync pending", rd[ql_pkg::IRQ_VSYNC_BIT], 1'b1);
    expect_equal("o_irq", o_irq, 1'b1);
    write_word({3'b000, ql_pkg::PORT_IPCIRQ}, 16'h0008, 1'b1, 1'b0);
    read_word({3'b000, ql_pkg::PORT_IPCIRQ}, rd);
    expect_equal("o_rdata[3] vsync pending", rd[ql_pkg::IRQ_VSYNC_BIT], 1'b0);
    expect_equal("o_irq", o_irq, 1'b0);
    i_vsync = 1'b1;
    pulse_key_event();
    read_word({3'b000, ql_pkg::PORT_IPCIRQ}, rd);
    expect_equal("o_rdata[1] key pending", rd[ql_pkg::IRQ_IPC_BIT], 1'b1);
    expect_equal("o_irq", o_irq, 1'b1);
    write_word({3'b000, ql_pkg::PORT_IPCIRQ}, 16'h0002, 1'b1, 1'b0);
    read_word({3'b000, ql_pkg::PORT_IPCIRQ}, rd);
    expect_equal("o_rdata[1] key pending", rd[ql_pkg::IRQ_IPC_BIT], 1'b0);
    expect_equal("o_irq", o_irq, 1'b0);

    // IPC status flag clears on the first read
    pulse_key_event();
    ipc_send_nibble(ql_pkg::IPC_CMD_STATUS);
    ipc_read_reply(8, reply);
    expect_equal("IPC status reply", reply, 16'h0001);
    ipc_send_nibble(ql_pkg::IPC_CMD_STATUS);
    ipc_read_reply(8, reply);
    expect_equal("IPC status reply", reply, 16'h0000);

    // IPC read key with an empty matrix on the last pass
    for (int n = 0; n <= 4; n++) begin
      i_kbd_matrix = random_matrix(2 * n);
      ipc_send_nibble(ql_pkg::IPC_CMD_READ_KEY);
      ipc_read_reply(16, reply);
      expect_equal("IPC read key reply", reply, read_key_reply(i_kbd_matrix));
    end

    // IPC key row and the keyboard port
    i_kbd_matrix = random_matrix(0);
    for (int r = 0; r < 8; r++) begin
      ipc_send_nibble(ql_pkg::IPC_CMD_KEYROW);
      ipc_send_nibble(4'(r));
      ipc_read_reply(8, reply);
      expect_equal("IPC key row reply", reply, matrix_row(i_kbd_matrix, r));
      read_word({3'(r), ql_pkg::PORT_KEYBD}, rd);
      expect_equal("o_rdata keyboard row", rd, {8'h00, matrix_row(i_kbd_matrix, r)});
    end

    // Display mode
    write_word({3'b000, ql_pkg::PORT_DISPLAY}, 16'h0000, 1'b1, 1'b0);
    expect_equal("o_display_mode", o_display_mode, 1'b0);
    write_word({3'b000, ql_pkg::PORT_DISPLAY}, 16'h0008, 1'b1, 1'b0);
    expect_equal("o_display_mode", o_display_mode, 1'b1);

    wait_cycles(2);
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             ql_io_top_inst.ql_io_checker_inst.fail_count);
    if (errors == 0 && ql_io_top_inst.ql_io_checker_inst.fail_count == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: vlog.f
common/ql_pkg.sv
ipc/ql_key_encoder.sv
ipc/ql_ipc.sv
hw/ql_rtc.sv
hw/ql_irq.sv
hw/ql_bus_regs.sv
hw/ql_io_top.sv
testbench/ql_io_checker.sv
testbench/tb_ql_io.sv

// File: Bender.yml
package:
  name: ql_io

sources:
  - common/ql_pkg.sv
  - ipc/ql_key_encoder.sv
  - ipc/ql_ipc.sv
  - hw/ql_rtc.sv
  - hw/ql_irq.sv
  - hw/ql_bus_regs.sv
  - hw/ql_io_top.sv
  - target: simulation
    files:
      - testbench/ql_io_checker.sv
      - testbench/tb_ql_io.sv
